// ==== verilog/cmdq_pkg.sv ====
// Shared widths, field indices and vector types for the command queue doorbell registers
`default_nettype none

package cmdq_pkg;

  // -------------------------------------------------------------------------
  // Port address and data
  // -------------------------------------------------------------------------
  localparam int reg_addr_w = 12;

  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [31:0]           reg_data_t;

  // Register index within a queue sits in address bits 4:2
  localparam int field_lsb  = 2;
  localparam int field_msb  = 4;
  localparam int num_fields = 5;

  typedef logic [field_msb-field_lsb:0] reg_field_t;
  // One write strobe per register of a queue
  typedef logic [num_fields-1:0]        field_sel_t;

  // -------------------------------------------------------------------------
  // Register map of one queue
  // -------------------------------------------------------------------------
  localparam reg_field_t field_tail_ptr = 3'd0;
  localparam reg_field_t field_irq_ctrl = 3'd1;
  localparam reg_field_t field_addr_lo  = 3'd2;
  localparam reg_field_t field_rst_ctrl = 3'd3;
  localparam reg_field_t field_addr_hi  = 3'd4;

  // Peer queue window at 0x100
  localparam int peer_bit       = 8;
  // Anything set from here up is an alias
  localparam int decode_top_bit = 9;

  // Interrupt control write, bit that raises a register interrupt
  localparam int ctrl_irq_bit     = 0;
  // Reset and interrupt configuration word
  localparam int cfg_irq_en_bit   = 0;
  localparam int cfg_irq_type_bit = 1;
  localparam int cfg_soft_rst_bit = 31;

  // Depth of the interrupt enable shift register
  localparam int irq_sr_w = 2;

endpackage

`default_nettype wire

// ==== verilog/cmdq_port_decode.sv ====
// Address decoder for both register ports, drives strobes, done pulses, clears and soft reset
`timescale 1ns/10ps
`default_nettype none

module cmdq_port_decode import cmdq_pkg::*; (
  input  wire logic      aclk,
  input  wire logic      aresetn,
  // Producer port requests
  input  wire logic      sq_wr_valid,
  input  wire reg_addr_t sq_wr_addr,
  input  wire logic      sq_rd_valid,
  input  wire reg_addr_t sq_rd_addr,
  // Consumer port requests
  input  wire logic      cq_wr_valid,
  input  wire reg_addr_t cq_wr_addr,
  input  wire logic      cq_rd_valid,
  input  wire reg_addr_t cq_rd_addr,
  // Soft reset requests from the banks
  input  wire logic      sq_rst_req,
  input  wire logic      cq_rst_req,
  // Field write strobes into each bank
  output field_sel_t     sq_wr_sel,
  output field_sel_t     cq_wr_sel,
  // Access completion
  output logic           sq_wr_done,
  output logic           cq_wr_done,
  output logic           sq_rd_done,
  output logic           cq_rd_done,
  // Read selection into each port's read mux
  output reg_field_t     sq_rd_field,
  output reg_field_t     cq_rd_field,
  output logic           sq_rd_peer,
  output logic           cq_rd_peer,
  output logic           sq_rd_hit,
  output logic           cq_rd_hit,
  // Interrupt status clears per queue
  output logic           sq_clr_tail,
  output logic           sq_clr_reg,
  output logic           cq_clr_tail,
  output logic           cq_clr_reg,
  output logic           soft_rst
);

  // -------------------------------------------------------------------------
  // Address checks
  // -------------------------------------------------------------------------

  // Legal register: no alias bits, no offset beyond 0x010 in either window
  function automatic logic addr_hit(input reg_addr_t addr);
    reg_field_t field;
    field = addr[field_msb:field_lsb];
    return (addr[reg_addr_w-1:decode_top_bit] == '0) &&
           (addr[peer_bit-1:field_msb+1] == '0) &&
           (field <= field_addr_hi);
  endfunction

  // One-hot strobe, own window only
  function automatic field_sel_t wr_strobe(input logic valid, input reg_addr_t addr);
    field_sel_t sel;
    sel = '0;
    if (valid && addr_hit(addr) && !addr[peer_bit])
      sel[addr[field_msb:field_lsb]] = 1'b1;
    return sel;
  endfunction

  assign sq_wr_sel = wr_strobe(sq_wr_valid, sq_wr_addr);
  assign cq_wr_sel = wr_strobe(cq_wr_valid, cq_wr_addr);

  // Read mux captures on the same edge as the access
  assign sq_rd_hit   = sq_rd_valid && addr_hit(sq_rd_addr);
  assign sq_rd_peer  = sq_rd_addr[peer_bit];
  assign sq_rd_field = sq_rd_addr[field_msb:field_lsb];
  assign cq_rd_hit   = cq_rd_valid && addr_hit(cq_rd_addr);
  assign cq_rd_peer  = cq_rd_addr[peer_bit];
  assign cq_rd_field = cq_rd_addr[field_msb:field_lsb];

  // Either bank can reset both queues
  assign soft_rst = sq_rst_req | cq_rst_req;

  // -------------------------------------------------------------------------
  // Done pulses and status clears
  // -------------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      sq_wr_done  <= 1'b0;
      cq_wr_done  <= 1'b0;
      sq_rd_done  <= 1'b0;
      cq_rd_done  <= 1'b0;
      sq_clr_tail <= 1'b0;
      sq_clr_reg  <= 1'b0;
      cq_clr_tail <= 1'b0;
      cq_clr_reg  <= 1'b0;
    end else begin
      // Every access completes, aliases included
      sq_wr_done  <= sq_wr_valid;
      cq_wr_done  <= cq_wr_valid;
      sq_rd_done  <= sq_rd_valid;
      cq_rd_done  <= cq_rd_valid;
      // Producer reading the consumer window
      cq_clr_tail <= sq_rd_hit && sq_rd_peer && (sq_rd_field == field_tail_ptr);
      cq_clr_reg  <= sq_rd_hit && sq_rd_peer && (sq_rd_field == field_irq_ctrl);
      // Consumer reading the producer window
      sq_clr_tail <= cq_rd_hit && cq_rd_peer && (cq_rd_field == field_tail_ptr);
      sq_clr_reg  <= cq_rd_hit && cq_rd_peer && (cq_rd_field == field_irq_ctrl);
    end
  end

  // At most one register written per port per cycle
  a_wr_sel_onehot: assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0(sq_wr_sel) && $onehot0(cq_wr_sel));

endmodule

`default_nettype wire

// ==== verilog/cmdq_queue_regs.sv ====
// Register bank of one queue, stores its registers and flags tail, interrupt and reset writes
`timescale 1ns/10ps
`default_nettype none

module cmdq_queue_regs import cmdq_pkg::*; (
  input  wire logic       aclk,
  input  wire logic       aresetn,
  // One-hot field strobe and port write data
  input  wire field_sel_t wr_sel,
  input  wire reg_data_t  wr_data,
  input  wire logic       soft_rst,
  // Stored registers
  output reg_data_t       tail_ptr,
  output reg_data_t       addr_lo,
  output reg_data_t       addr_hi,
  output logic            irq_en,
  output logic            irq_type,
  // Write events, one cycle each
  output logic            tail_wr,
  output logic            irq_wr,
  output logic            rst_req
);

  // -------------------------------------------------------------------------
  // Stored registers
  // -------------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn || soft_rst) begin
      tail_ptr <= '0;
      addr_lo  <= '0;
      addr_hi  <= '0;
      irq_en   <= 1'b0;
      irq_type <= 1'b0;
    end else begin
      if (wr_sel[field_tail_ptr])
        tail_ptr <= wr_data;
      if (wr_sel[field_addr_lo])
        addr_lo <= wr_data;
      if (wr_sel[field_addr_hi])
        addr_hi <= wr_data;
      // Configuration keeps only enable and type
      if (wr_sel[field_rst_ctrl]) begin
        irq_en   <= wr_data[cfg_irq_en_bit];
        irq_type <= wr_data[cfg_irq_type_bit];
      end
    end
  end

  // -------------------------------------------------------------------------
  // Write events
  // -------------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      tail_wr <= 1'b0;
      irq_wr  <= 1'b0;
      rst_req <= 1'b0;
    end else begin
      // Doorbell on any tail pointer write
      tail_wr <= wr_sel[field_tail_ptr];
      // Interrupt control only rings with its bit set
      irq_wr  <= wr_sel[field_irq_ctrl] && wr_data[ctrl_irq_bit];
      // Decoder turns this into soft_rst for both queues
      rst_req <= wr_sel[field_rst_ctrl] && wr_data[cfg_soft_rst_bit];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cmdq_irq_gen.sv ====
// Interrupt status and output of one queue, with the enable shift register after clears
`timescale 1ns/10ps
`default_nettype none

module cmdq_irq_gen import cmdq_pkg::*; (
  input  wire logic aclk,
  input  wire logic aresetn,
  // Write events from the bank
  input  wire logic tail_wr,
  input  wire logic irq_wr,
  // Configuration, type high selects register interrupts
  input  wire logic irq_en,
  input  wire logic irq_type,
  // Clears from peer reads
  input  wire logic clr_tail,
  input  wire logic clr_reg,
  input  wire logic soft_rst,
  output logic      irq,
  output logic      pending,
  output logic      reg_status
);

  logic                tail_status;
  logic [irq_sr_w-1:0] en_sr;
  logic                clr_hit;

  // Only the clear matching the active type counts
  assign clr_hit = (clr_reg && irq_type) || (clr_tail && !irq_type) || soft_rst;
  assign pending = reg_status | tail_status;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      en_sr       <= '0;
      reg_status  <= 1'b0;
      tail_status <= 1'b0;
      irq         <= 1'b0;
    end else begin
      // Emptied on a clear so irq falls before it can rise again
      if (clr_hit)
        en_sr <= '0;
      else
        en_sr <= {en_sr[irq_sr_w-2:0], 1'b1};

      // Register status, held at zero under tail type
      if (soft_rst || !irq_type)
        reg_status <= 1'b0;
      else if (irq_wr)
        reg_status <= 1'b1;
      else if (clr_reg)
        reg_status <= 1'b0;

      // Tail status, held at zero under register type
      if (soft_rst || irq_type)
        tail_status <= 1'b0;
      else if (tail_wr)
        tail_status <= 1'b1;
      else if (clr_tail)
        tail_status <= 1'b0;

      irq <= irq_en && pending && en_sr[irq_sr_w-1];
    end
  end

  // Forced low gap after every clear
  a_irq_gap_after_clear: assert property (@(posedge aclk) disable iff (!aresetn)
    clr_hit |=> ##1 !irq [*irq_sr_w]);

endmodule

`default_nettype wire

// ==== verilog/cmdq_read_mux.sv ====
// Registered read data of one port over its own queue and the peer queue
`timescale 1ns/10ps
`default_nettype none

module cmdq_read_mux import cmdq_pkg::*; (
  input  wire logic       aclk,
  input  wire logic       aresetn,
  // Selection from the decoder
  input  wire logic       rd_hit,
  input  wire logic       rd_peer,
  input  wire reg_field_t rd_field,
  // Own queue
  input  wire reg_data_t  own_tail_ptr,
  input  wire reg_data_t  own_addr_lo,
  input  wire reg_data_t  own_addr_hi,
  input  wire logic       own_irq_en,
  input  wire logic       own_irq_type,
  input  wire logic       own_pending,
  input  wire logic       own_reg_status,
  // Peer queue
  input  wire reg_data_t  peer_tail_ptr,
  input  wire reg_data_t  peer_addr_lo,
  input  wire reg_data_t  peer_addr_hi,
  input  wire logic       peer_irq_en,
  input  wire logic       peer_irq_type,
  input  wire logic       peer_pending,
  input  wire logic       peer_reg_status,
  output reg_data_t       rd_data
);

  reg_data_t sel_tail_ptr;
  reg_data_t sel_addr_lo;
  reg_data_t sel_addr_hi;
  logic      sel_irq_en;
  logic      sel_irq_type;
  logic      sel_pending;
  logic      sel_reg_status;

  // Pick the window first
  assign sel_tail_ptr   = rd_peer ? peer_tail_ptr   : own_tail_ptr;
  assign sel_addr_lo    = rd_peer ? peer_addr_lo    : own_addr_lo;
  assign sel_addr_hi    = rd_peer ? peer_addr_hi    : own_addr_hi;
  assign sel_irq_en     = rd_peer ? peer_irq_en     : own_irq_en;
  assign sel_irq_type   = rd_peer ? peer_irq_type   : own_irq_type;
  assign sel_pending    = rd_peer ? peer_pending    : own_pending;
  assign sel_reg_status = rd_peer ? peer_reg_status : own_reg_status;

  // -------------------------------------------------------------------------
  // Field select, sampled before any same-cycle write lands
  // -------------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_data <= '0;
    end else begin
      rd_data <= '0;
      if (rd_hit) begin
        case (rd_field)
          field_tail_ptr: rd_data <= sel_tail_ptr;
          field_irq_ctrl: begin
            // Own side sees pending, peer side sees register status
            rd_data[1] <= !rd_peer && sel_pending;
            rd_data[0] <= rd_peer && sel_reg_status;
          end
          field_addr_lo:  rd_data <= sel_addr_lo;
          field_rst_ctrl: begin
            rd_data[cfg_irq_type_bit] <= sel_irq_type;
            rd_data[cfg_irq_en_bit]   <= sel_irq_en;
          end
          field_addr_hi:  rd_data <= sel_addr_hi;
          default:        rd_data <= '0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cmdq_regs_top.sv ====
// Doorbell register block top, connects decoder, queue banks, interrupt logic and read muxes
`timescale 1ns/10ps
`default_nettype none

module cmdq_regs_top import cmdq_pkg::*; (
  input  wire logic      aclk,
  input  wire logic      aresetn,
  // Producer port
  input  wire logic      sq_wr_valid,
  input  wire reg_addr_t sq_wr_addr,
  input  wire reg_data_t sq_wr_data,
  output logic           sq_wr_done,
  input  wire logic      sq_rd_valid,
  input  wire reg_addr_t sq_rd_addr,
  output reg_data_t      sq_rd_data,
  output logic           sq_rd_done,
  // Consumer port
  input  wire logic      cq_wr_valid,
  input  wire reg_addr_t cq_wr_addr,
  input  wire reg_data_t cq_wr_data,
  output logic           cq_wr_done,
  input  wire logic      cq_rd_valid,
  input  wire reg_addr_t cq_rd_addr,
  output reg_data_t      cq_rd_data,
  output logic           cq_rd_done,
  // Interrupts
  output logic           irq_sq,
  output logic           irq_cq
);

  // -------------------------------------------------------------------------
  // Internal nets
  // -------------------------------------------------------------------------
  field_sel_t sq_wr_sel, cq_wr_sel;
  reg_field_t sq_rd_field, cq_rd_field;
  logic       sq_rd_peer, cq_rd_peer, sq_rd_hit, cq_rd_hit;
  logic       sq_clr_tail, sq_clr_reg, cq_clr_tail, cq_clr_reg;
  logic       sq_rst_req, cq_rst_req, soft_rst;
  // Queue state
  reg_data_t  sq_tail_ptr, sq_addr_lo, sq_addr_hi;
  reg_data_t  cq_tail_ptr, cq_addr_lo, cq_addr_hi;
  logic       sq_irq_en, sq_irq_type, sq_tail_wr, sq_irq_wr, sq_pending, sq_reg_status;
  logic       cq_irq_en, cq_irq_type, cq_tail_wr, cq_irq_wr, cq_pending, cq_reg_status;

  cmdq_port_decode u_decode (
    .aclk, .aresetn,
    .sq_wr_valid, .sq_wr_addr, .sq_rd_valid, .sq_rd_addr,
    .cq_wr_valid, .cq_wr_addr, .cq_rd_valid, .cq_rd_addr,
    .sq_rst_req, .cq_rst_req,
    .sq_wr_sel, .cq_wr_sel,
    .sq_wr_done, .cq_wr_done, .sq_rd_done, .cq_rd_done,
    .sq_rd_field, .cq_rd_field, .sq_rd_peer, .cq_rd_peer, .sq_rd_hit, .cq_rd_hit,
    .sq_clr_tail, .sq_clr_reg, .cq_clr_tail, .cq_clr_reg,
    .soft_rst
  );

  // Each bank takes writes from its own port only
  cmdq_queue_regs u_sq_regs (
    .aclk, .aresetn, .wr_sel(sq_wr_sel), .wr_data(sq_wr_data), .soft_rst,
    .tail_ptr(sq_tail_ptr), .addr_lo(sq_addr_lo), .addr_hi(sq_addr_hi),
    .irq_en(sq_irq_en), .irq_type(sq_irq_type),
    .tail_wr(sq_tail_wr), .irq_wr(sq_irq_wr), .rst_req(sq_rst_req)
  );

  cmdq_queue_regs u_cq_regs (
    .aclk, .aresetn, .wr_sel(cq_wr_sel), .wr_data(cq_wr_data), .soft_rst,
    .tail_ptr(cq_tail_ptr), .addr_lo(cq_addr_lo), .addr_hi(cq_addr_hi),
    .irq_en(cq_irq_en), .irq_type(cq_irq_type),
    .tail_wr(cq_tail_wr), .irq_wr(cq_irq_wr), .rst_req(cq_rst_req)
  );

  cmdq_irq_gen u_sq_irq (
    .aclk, .aresetn, .tail_wr(sq_tail_wr), .irq_wr(sq_irq_wr),
    .irq_en(sq_irq_en), .irq_type(sq_irq_type),
    .clr_tail(sq_clr_tail), .clr_reg(sq_clr_reg), .soft_rst,
    .irq(irq_sq), .pending(sq_pending), .reg_status(sq_reg_status)
  );

  cmdq_irq_gen u_cq_irq (
    .aclk, .aresetn, .tail_wr(cq_tail_wr), .irq_wr(cq_irq_wr),
    .irq_en(cq_irq_en), .irq_type(cq_irq_type),
    .clr_tail(cq_clr_tail), .clr_reg(cq_clr_reg), .soft_rst,
    .irq(irq_cq), .pending(cq_pending), .reg_status(cq_reg_status)
  );

  // Producer port reads, the consumer queue is its peer
  cmdq_read_mux u_sq_rd (
    .aclk, .aresetn, .rd_hit(sq_rd_hit), .rd_peer(sq_rd_peer), .rd_field(sq_rd_field),
    .own_tail_ptr(sq_tail_ptr), .own_addr_lo(sq_addr_lo), .own_addr_hi(sq_addr_hi),
    .own_irq_en(sq_irq_en), .own_irq_type(sq_irq_type),
    .own_pending(sq_pending), .own_reg_status(sq_reg_status),
    .peer_tail_ptr(cq_tail_ptr), .peer_addr_lo(cq_addr_lo), .peer_addr_hi(cq_addr_hi),
    .peer_irq_en(cq_irq_en), .peer_irq_type(cq_irq_type),
    .peer_pending(cq_pending), .peer_reg_status(cq_reg_status),
    .rd_data(sq_rd_data)
  );

  cmdq_read_mux u_cq_rd (
    .aclk, .aresetn, .rd_hit(cq_rd_hit), .rd_peer(cq_rd_peer), .rd_field(cq_rd_field),
    .own_tail_ptr(cq_tail_ptr), .own_addr_lo(cq_addr_lo), .own_addr_hi(cq_addr_hi),
    .own_irq_en(cq_irq_en), .own_irq_type(cq_irq_type),
    .own_pending(cq_pending), .own_reg_status(cq_reg_status),
    .peer_tail_ptr(sq_tail_ptr), .peer_addr_lo(sq_addr_lo), .peer_addr_hi(sq_addr_hi),
    .peer_irq_en(sq_irq_en), .peer_irq_type(sq_irq_type),
    .peer_pending(sq_pending), .peer_reg_status(sq_reg_status),
    .rd_data(cq_rd_data)
  );

endmodule

`default_nettype wire

// ==== dv/cmdq_model.svh ====
// Reference model of both queues, included inside the testbench module, index 0 is SQ and 1 is CQ
`ifndef CMDQ_MODEL_SVH
`define CMDQ_MODEL_SVH

// Stored registers per queue
reg_data_t  m_tail [2];
reg_data_t  m_addr_lo [2];
reg_data_t  m_addr_hi [2];
logic [1:0] m_irq_en;
logic [1:0] m_irq_type;
// Interrupt status per queue, type high means register interrupts
logic [1:0] m_reg_st;
logic [1:0] m_tail_st;

// Power-on and soft reset state
function automatic void clear_queues();
  for (int q = 0; q < 2; q++) begin
    m_tail[q]    = '0;
    m_addr_lo[q] = '0;
    m_addr_hi[q] = '0;
  end
  m_irq_en   = '0;
  m_irq_type = '0;
  m_reg_st   = '0;
  m_tail_st  = '0;
endfunction

// Registers live at 0x000 to 0x010 in either window
function automatic bit in_map(input reg_addr_t addr);
  reg_addr_t off;
  off           = addr;
  off[peer_bit] = 1'b0;
  return off <= reg_addr_t'('h010);
endfunction

function automatic void apply_write(input int p, input reg_addr_t addr, input reg_data_t data);
  reg_field_t f;
  f = addr[4:2];
  // Own window only, peer and unmapped writes are dropped
  if (!in_map(addr) || addr[peer_bit])
    return;
  case (f)
    field_tail_ptr: begin
      m_tail[p] = data;
      if (!m_irq_type[p])
        m_tail_st[p] = 1'b1;
    end
    field_irq_ctrl: begin
      if (data[0] && m_irq_type[p])
        m_reg_st[p] = 1'b1;
    end
    field_addr_lo: m_addr_lo[p] = data;
    field_rst_ctrl: begin
      if (data[cfg_soft_rst_bit]) begin
        clear_queues();
      end else begin
        m_irq_en[p]   = data[cfg_irq_en_bit];
        m_irq_type[p] = data[cfg_irq_type_bit];
        // Status of the inactive type is dropped
        if (data[cfg_irq_type_bit])
          m_tail_st[p] = 1'b0;
        else
          m_reg_st[p] = 1'b0;
      end
    end
    field_addr_hi: m_addr_hi[p] = data;
    default: ;
  endcase
endfunction

// Expected read data, peer reads of 0x100 and 0x104 clear the peer's status
function automatic reg_data_t predict_read(input int p, input reg_addr_t addr);
  int         q;
  reg_field_t f;
  reg_data_t  d;
  d = '0;
  f = addr[4:2];
  q = addr[peer_bit] ? 1 - p : p;
  if (!in_map(addr))
    return d;
  case (f)
    field_tail_ptr: begin
      d = m_tail[q];
      if (q != p)
        m_tail_st[q] = 1'b0;
    end
    field_irq_ctrl: begin
      if (q == p) begin
        d[1] = m_reg_st[q] | m_tail_st[q];
      end else begin
        d[0]        = m_reg_st[q];
        m_reg_st[q] = 1'b0;
      end
    end
    field_addr_lo:  d = m_addr_lo[q];
    field_rst_ctrl: d = {30'd0, m_irq_type[q], m_irq_en[q]};
    field_addr_hi:  d = m_addr_hi[q];
    default: ;
  endcase
  return d;
endfunction

function automatic bit expect_irq(input int q);
  return m_irq_en[q] && (m_reg_st[q] || m_tail_st[q]);
endfunction

`endif

// ==== dv/tb_cmdq_regs.sv ====
// Testbench for the doorbell register block, directed and random accesses checked against a model
`timescale 1ns/10ps
`default_nettype none

module tb_cmdq_regs import cmdq_pkg::*; ();

  localparam int clk_period = 4;
  localparam int n_random   = 400;
  localparam int n_directed = 40;
  localparam int rand_seed  = 96401;

  logic                         aclk;
  logic                         aresetn;
  // Index 0 is the producer port, 1 the consumer port
  logic [1:0]                   wr_valid;
  logic [1:0][reg_addr_w-1:0]   wr_addr;
  logic [1:0][31:0]             wr_data;
  logic [1:0]                   rd_valid;
  logic [1:0][reg_addr_w-1:0]   rd_addr;
  wire  [1:0]                   wr_done;
  wire  [1:0]                   rd_done;
  wire  [1:0][31:0]             rd_data;
  wire  [1:0]                   irq;
  int                           n_checks;
  int                           n_errors;

  `include "cmdq_model.svh"

  cmdq_regs_top dut (
    .aclk(aclk), .aresetn(aresetn),
    .sq_wr_valid(wr_valid[0]), .sq_wr_addr(wr_addr[0]), .sq_wr_data(wr_data[0]),
    .sq_wr_done(wr_done[0]), .sq_rd_valid(rd_valid[0]), .sq_rd_addr(rd_addr[0]),
    .sq_rd_data(rd_data[0]), .sq_rd_done(rd_done[0]),
    .cq_wr_valid(wr_valid[1]), .cq_wr_addr(wr_addr[1]), .cq_wr_data(wr_data[1]),
    .cq_wr_done(wr_done[1]), .cq_rd_valid(rd_valid[1]), .cq_rd_addr(rd_addr[1]),
    .cq_rd_data(rd_data[1]), .cq_rd_done(rd_done[1]),
    .irq_sq(irq[0]), .irq_cq(irq[1])
  );

  always #(clk_period / 2) aclk = ~aclk;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic check_value(input string name, input reg_data_t expected,
                             input reg_data_t actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // One access, write and read may share the cycle, then two idle cycles
  task automatic port_access(input int p, input bit do_wr, input reg_addr_t waddr,
                             input reg_data_t wdata, input bit do_rd, input reg_addr_t raddr);
    string     pfx;
    reg_data_t exp_rd;
    pfx         = (p == 0) ? "sq" : "cq";
    wr_valid[p] = do_wr;
    wr_addr[p]  = waddr;
    wr_data[p]  = wdata;
    rd_valid[p] = do_rd;
    rd_addr[p]  = raddr;
    // Read sees the state from before this cycle's write
    exp_rd = do_rd ? predict_read(p, raddr) : '0;
    if (do_wr)
      apply_write(p, waddr, wdata);
    @(posedge aclk);
    #1;
    wr_valid[p] = 1'b0;
    rd_valid[p] = 1'b0;
    check_value({pfx, "_wr_done"}, do_wr, wr_done[p]);
    check_value({pfx, "_rd_done"}, do_rd, rd_done[p]);
    if (do_rd)
      check_value({pfx, "_rd_data"}, exp_rd, rd_data[p]);
    // Done is a single-cycle pulse
    repeat (2) begin
      @(posedge aclk);
      #1;
      check_value({pfx, "_wr_done"}, '0, wr_done[p]);
      check_value({pfx, "_rd_done"}, '0, rd_done[p]);
    end
  endtask

  // Interrupts compared only once they have settled
  task automatic irq_after_idle();
    repeat (8) @(posedge aclk);
    #1;
    check_value("irq_sq", expect_irq(0), irq[0]);
    check_value("irq_cq", expect_irq(1), irq[1]);
  endtask

  // Mostly mapped registers, sometimes an alias bit or an unused offset
  function automatic reg_addr_t rand_addr();
    reg_addr_t a;
    a = reg_addr_t'($urandom_range(4, 0) << 2);
    if ($urandom_range(1, 0) != 0)
      a[peer_bit] = 1'b1;
    case ($urandom_range(9, 0))
      0: a[$urandom_range(reg_addr_w - 1, decode_top_bit)] = 1'b1;
      1: a[7:2] = 6'($urandom_range(63, 5));
      default: ;
    endcase
    return a;
  endfunction

  task automatic random_access();
    int        op;
    reg_data_t data;
    op   = $urandom_range(2, 0);
    data = $urandom;
    // Keep soft resets rare
    if ($urandom_range(7, 0) != 0)
      data[cfg_soft_rst_bit] = 1'b0;
    port_access($urandom_range(1, 0), op != 1, rand_addr(), data, op != 0, rand_addr());
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    aclk     = 1'b0;
    aresetn  = 1'b0;
    wr_valid = '0;
    wr_addr  = '0;
    wr_data  = '0;
    rd_valid = '0;
    rd_addr  = '0;
    n_checks = 0;
    n_errors = 0;
    void'($urandom(rand_seed));
    clear_queues();
    repeat (10) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    repeat (2) @(posedge aclk);
    #1;
    check_value("irq", '0, irq);
    check_value("done", '0, {wr_done, rd_done});

    // Register interrupt on SQ, cleared by the consumer reading 0x104
    port_access(0, 1, 12'h00C, 32'h3, 0, '0);
    port_access(0, 1, 12'h004, 32'h1, 0, '0);
    irq_after_idle();
    port_access(0, 0, '0, '0, 1, 12'h004);
    port_access(1, 0, '0, '0, 1, 12'h104);
    irq_after_idle();
    // Disabled, status builds up but irq stays low
    port_access(0, 1, 12'h00C, 32'h2, 0, '0);
    port_access(0, 1, 12'h004, 32'h1, 0, '0);
    irq_after_idle();
    // Tail interrupt on CQ, 0x104 leaves it and 0x100 clears it
    port_access(1, 1, 12'h00C, 32'h1, 0, '0);
    port_access(1, 1, 12'h000, $urandom, 0, '0);
    irq_after_idle();
    port_access(0, 0, '0, '0, 1, 12'h104);
    irq_after_idle();
    port_access(0, 0, '0, '0, 1, 12'h100);
    irq_after_idle();
    // Peer window is read only
    port_access(0, 1, 12'h108, $urandom, 1, 12'h108);
    port_access(1, 0, '0, '0, 1, 12'h008);
    // Both interrupts up, then a consumer soft reset
    port_access(0, 1, 12'h00C, 32'h3, 0, '0);
    port_access(1, 1, 12'h000, $urandom, 0, '0);
    irq_after_idle();
    port_access(1, 1, 12'h00C, 32'h8000_0000, 0, '0);
    irq_after_idle();
    port_access(0, 0, '0, '0, 1, 12'h100);
    port_access(1, 0, '0, '0, 1, 12'h10C);
    // Producer soft reset clears the consumer queue as well
    port_access(1, 1, 12'h008, $urandom, 0, '0);
    port_access(0, 1, 12'h00C, 32'h3, 0, '0);
    port_access(0, 1, 12'h004, 32'h1, 0, '0);
    irq_after_idle();
    port_access(0, 1, 12'h00C, 32'h8000_0003, 0, '0);
    irq_after_idle();
    port_access(0, 0, '0, '0, 1, 12'h108);
    port_access(1, 0, '0, '0, 1, 12'h10C);

    for (int i = 0; i < n_random; i++) begin
      random_access();
      if (i % 20 == 19)
        irq_after_idle();
    end
    irq_after_idle();

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  // Watchdog
  initial begin
    #((n_random + n_directed) * 50 * clk_period);
    $display("Watchdog expired at %0t with the tests still running", $time);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/cmdq_pkg.sv
verilog/cmdq_port_decode.sv
verilog/cmdq_queue_regs.sv
verilog/cmdq_irq_gen.sv
verilog/cmdq_read_mux.sv
verilog/cmdq_regs_top.sv
+incdir+dv
dv/tb_cmdq_regs.sv
